/* hw/ins_decoder_pkg.sv */
// shared decoder types; byte and phase widths are fixed by the 8051 opcode set
package ins_decoder_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [3:0] phase_t;     // micro-steps still to run
    typedef logic [1:0] reg_bank_t;  // PSW bank select

    typedef enum logic [1:0] {
        STEP_FETCH,
        STEP_RAM_READ,
        STEP_RAM_WRITE,
        STEP_PROCESS
    } step_kind_e;

    typedef enum logic [1:0] {
        SRC_A,
        SRC_RAM_DATA,
        SRC_ROM_DATA,
        SRC_NONE
    } data_src_e;

    typedef enum logic [3:0] {
        ALU_MOV,
        ALU_ADD,
        ALU_ADDC,
        ALU_SUBB,
        ALU_ORL,
        ALU_ANL,
        ALU_XRL,
        ALU_INC,
        ALU_DEC,
        ALU_CLR,
        ALU_CPL
    } alu_op_e;

    typedef enum logic [2:0] {
        OP_MOV_TO_A,
        OP_MOV_FROM_A,
        OP_MOV_IMM,      // mov dest,#data
        OP_MOV_DIR_DIR,
        OP_ALU_A,
        OP_INC_DEC,
        OP_A_UNARY,      // clr a / cpl a
        OP_SKIP
    } ins_op_e;

    typedef enum logic [2:0] {
        MODE_ACC,
        MODE_RN,
        MODE_RI,
        MODE_DIRECT,
        MODE_IMM
    } operand_mode_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_BUSY
    } seq_state_e;

    typedef struct packed {
        byte_t         opcode;
        ins_op_e       op;
        operand_mode_e mode;    // source mode, or destination for mov-from-a / mov-imm
        alu_op_e       alu_op;
        phase_t        steps;
    } ins_class_t;

    typedef struct packed {
        step_kind_e kind;
        byte_t      addr;
        data_src_e  a_src;   // write data or alu operand a
        data_src_e  b_src;
        alu_op_e    alu_op;
    } micro_step_t;

    typedef struct packed {
        byte_t rom_data;
        byte_t ram_data;     // ram read data or alu result
    } step_resp_t;

endpackage

/* hw/opcode_classifier.sv */
// combinational decode; jumps, calls, stack, bit ops, mul/div and rotates all map to a zero-step skip
`timescale 1ns/10ps
module opcode_classifier (
    input  ins_decoder_pkg::byte_t      opcode,
    output ins_decoder_pkg::ins_class_t ins_class
);
    import ins_decoder_pkg::*;

    logic [3:0]    hi;
    logic [3:0]    lo;
    operand_mode_e src_mode;
    ins_op_e       op;
    operand_mode_e mode;
    alu_op_e       alu_op;

    function automatic phase_t step_count(ins_op_e f, operand_mode_e m);
        phase_t n;
        n = '0;
        case (f)
            OP_MOV_TO_A, OP_ALU_A: n = (m == MODE_RN || m == MODE_IMM) ? 4'd2 : 4'd3;
            OP_MOV_FROM_A:         n = (m == MODE_RN) ? 4'd1 : 4'd2;
            OP_MOV_IMM:            n = (m == MODE_RN) ? 4'd2 : 4'd3;
            OP_MOV_DIR_DIR:        n = 4'd4;
            OP_INC_DEC: begin
                case (m)
                    MODE_ACC: n = 4'd1;
                    MODE_RN:  n = 4'd3;
                    default:  n = 4'd4;
                endcase
            end
            OP_A_UNARY:            n = 4'd1;
            default:               n = '0;
        endcase
        return n;
    endfunction

    assign hi = opcode[7:4];
    assign lo = opcode[3:0];

    // low nibble 4..f: 4 imm, 5 direct, 6/7 @ri, 8..f rn
    always_comb begin
        if (lo[3])
            src_mode = MODE_RN;
        else if (lo[1])
            src_mode = MODE_RI;
        else if (lo[0])
            src_mode = MODE_DIRECT;
        else
            src_mode = MODE_IMM;
    end

    always_comb begin
        op     = OP_SKIP;
        mode   = src_mode;
        alu_op = ALU_MOV;
        if (lo >= 4'h4) begin
            case (hi)
                4'h0, 4'h1: begin
                    op     = OP_INC_DEC;
                    mode   = (src_mode == MODE_IMM) ? MODE_ACC : src_mode;  // x4 is inc/dec a
                    alu_op = opcode[4] ? ALU_DEC : ALU_INC;
                end
                4'h2, 4'h3: begin
                    op     = OP_ALU_A;
                    alu_op = opcode[4] ? ALU_ADDC : ALU_ADD;
                end
                4'h4: begin
                    op     = OP_ALU_A;
                    alu_op = ALU_ORL;
                end
                4'h5: begin
                    op     = OP_ALU_A;
                    alu_op = ALU_ANL;
                end
                4'h6: begin
                    op     = OP_ALU_A;
                    alu_op = ALU_XRL;
                end
                4'h9: begin
                    op     = OP_ALU_A;
                    alu_op = ALU_SUBB;
                end
                4'h7: op = (src_mode == MODE_IMM) ? OP_MOV_TO_A : OP_MOV_IMM;  // 74 is mov a,#data
                4'h8: op = (lo == 4'h5) ? OP_MOV_DIR_DIR : OP_SKIP;
                4'he: begin
                    op     = (src_mode == MODE_IMM) ? OP_A_UNARY : OP_MOV_TO_A;
                    alu_op = (src_mode == MODE_IMM) ? ALU_CLR : ALU_MOV;
                end
                4'hf: begin
                    op     = (src_mode == MODE_IMM) ? OP_A_UNARY : OP_MOV_FROM_A;
                    alu_op = (src_mode == MODE_IMM) ? ALU_CPL : ALU_MOV;
                end
                default: op = OP_SKIP;
            endcase
        end
        if (op == OP_SKIP || op == OP_A_UNARY)
            mode = MODE_ACC;
    end

    assign ins_class = '{opcode: opcode, op: op, mode: mode, alu_op: alu_op,
                         steps: step_count(op, mode)};

endmodule

/* hw/phase_sequencer.sv */
// one instruction in flight; zero-step opcodes never leave idle, step_valid holds until step_ready
`timescale 1ns/10ps
module phase_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ins_valid,
    input  ins_decoder_pkg::ins_class_t ins_class,
    input  logic                        step_ready,
    output logic                        ins_ready,
    output logic                        step_valid,
    output logic                        step_accept,
    output ins_decoder_pkg::ins_class_t cur_class,
    output ins_decoder_pkg::phase_t     phase
);
    import ins_decoder_pkg::*;

    seq_state_e state;

    assign ins_ready   = (state == SEQ_IDLE);
    assign step_valid  = (state == SEQ_BUSY);
    assign step_accept = step_valid && step_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SEQ_IDLE;
            phase     <= '0;
            cur_class <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (ins_valid) begin
                        cur_class <= ins_class;
                        phase     <= ins_class.steps;
                        if (ins_class.steps != '0)
                            state <= SEQ_BUSY;   // nop / unknown stay idle
                    end
                end
                SEQ_BUSY: begin
                    if (step_accept) begin
                        phase <= phase - 1'b1;
                        if (phase == 4'd1)
                            state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // busy always has at least the current step left
    a_busy_phase: assert property (@(posedge clk) disable iff (!rst_n)
        state == SEQ_BUSY |-> phase != '0);

    // an offered step stays put, class and phase included, until taken
    a_step_hold: assert property (@(posedge clk) disable iff (!rst_n)
        step_valid && !step_ready |=> step_valid && $stable(phase) && $stable(cur_class));

endmodule

/* hw/step_generator.sv */
// register_bank must stay stable for a whole instruction; returned bytes are latched only on accept
`timescale 1ns/10ps
module step_generator (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ins_decoder_pkg::ins_class_t  cur_class,
    input  ins_decoder_pkg::phase_t      phase,
    input  ins_decoder_pkg::reg_bank_t   register_bank,
    input  logic                         step_accept,
    input  ins_decoder_pkg::step_resp_t  resp,
    output ins_decoder_pkg::micro_step_t step
);
    import ins_decoder_pkg::*;

    byte_t     last_rom;
    byte_t     last_ram;
    byte_t     scratch;     // mov dir,#data target or inc/dec @ri pointer
    byte_t     scratch_d;
    logic      scratch_ld;
    byte_t     rn_addr;
    byte_t     ri_addr;
    phase_t    idx;
    logic      first_step;
    logic      last_step;
    data_src_e wr_src;
    data_src_e b_last;

    function automatic micro_step_t fetch_step();
        micro_step_t s;
        s      = '0;
        s.kind = STEP_FETCH;
        return s;
    endfunction

    function automatic micro_step_t read_step(byte_t a);
        micro_step_t s;
        s      = '0;
        s.kind = STEP_RAM_READ;
        s.addr = a;
        return s;
    endfunction

    function automatic micro_step_t write_step(data_src_e src, byte_t a);
        micro_step_t s;
        s       = '0;
        s.kind  = STEP_RAM_WRITE;
        s.addr  = a;
        s.a_src = src;
        return s;
    endfunction

    function automatic micro_step_t proc_step(data_src_e a, data_src_e b, alu_op_e op);
        micro_step_t s;
        s        = '0;
        s.kind   = STEP_PROCESS;
        s.a_src  = a;
        s.b_src  = b;
        s.alu_op = op;
        return s;
    endfunction

    function automatic micro_step_t unary_step(data_src_e a, alu_op_e op);
        micro_step_t s;
        s        = '0;
        s.kind   = STEP_PROCESS;
        s.a_src  = a;
        s.alu_op = op;
        return s;
    endfunction

    function automatic data_src_e write_src(ins_op_e f);
        case (f)
            OP_MOV_FROM_A:              return SRC_A;
            OP_MOV_IMM:                 return SRC_ROM_DATA;
            OP_MOV_DIR_DIR, OP_INC_DEC: return SRC_RAM_DATA;
            default:                    return SRC_NONE;  // family never writes ram
        endcase
    endfunction

    assign rn_addr    = {3'b000, register_bank, cur_class.opcode[2:0]};
    assign ri_addr    = {3'b000, register_bank, 2'b00, cur_class.opcode[0]};
    assign idx        = cur_class.steps - phase;   // 0 for the first step
    assign first_step = (idx == 4'd0);
    assign last_step  = (phase == 4'd1);
    assign wr_src     = write_src(cur_class.op);
    assign b_last     = (cur_class.mode == MODE_IMM) ? SRC_ROM_DATA : SRC_RAM_DATA;

    always_comb begin
        step       = '0;
        scratch_ld = 1'b0;
        scratch_d  = last_ram;
        case (cur_class.op)
            OP_MOV_TO_A, OP_ALU_A: begin
                if (last_step) begin
                    step = proc_step(SRC_A, b_last, cur_class.alu_op);
                end else begin
                    case (cur_class.mode)
                        MODE_RN:     step = read_step(rn_addr);
                        MODE_RI:     step = first_step ? read_step(ri_addr) : read_step(last_ram);
                        MODE_DIRECT: step = first_step ? fetch_step() : read_step(last_rom);
                        MODE_IMM:    step = fetch_step();
                        default:     step = '0;
                    endcase
                end
            end
            OP_MOV_FROM_A: begin
                case (cur_class.mode)
                    MODE_RN:     step = write_step(wr_src, rn_addr);
                    MODE_RI:     step = first_step ? read_step(ri_addr) : write_step(wr_src, last_ram);
                    MODE_DIRECT: step = first_step ? fetch_step() : write_step(wr_src, last_rom);
                    default:     step = '0;
                endcase
            end
            OP_MOV_IMM: begin
                if (last_step) begin
                    case (cur_class.mode)
                        MODE_RN:     step = write_step(wr_src, rn_addr);
                        MODE_RI:     step = write_step(wr_src, last_ram);
                        MODE_DIRECT: step = write_step(wr_src, scratch);
                        default:     step = '0;
                    endcase
                end else if (cur_class.mode == MODE_RI && first_step) begin
                    step = read_step(ri_addr);
                end else begin
                    step       = fetch_step();
                    scratch_ld = first_step && (cur_class.mode == MODE_DIRECT);
                    scratch_d  = resp.rom_data;   // destination address byte
                end
            end
            OP_MOV_DIR_DIR: begin
                case (idx)
                    4'd1:    step = read_step(last_rom);
                    4'd3:    step = write_step(wr_src, last_rom);
                    default: step = fetch_step();
                endcase
            end
            OP_INC_DEC: begin
                if (cur_class.mode == MODE_ACC) begin
                    step = unary_step(SRC_A, cur_class.alu_op);
                end else if (last_step) begin
                    case (cur_class.mode)
                        MODE_RN: step = write_step(wr_src, rn_addr);
                        MODE_RI: step = write_step(wr_src, scratch);
                        default: step = write_step(wr_src, last_rom);
                    endcase
                end else if (phase == 4'd2) begin
                    step = unary_step(SRC_RAM_DATA, cur_class.alu_op);
                end else if (first_step) begin
                    case (cur_class.mode)
                        MODE_RN: step = read_step(rn_addr);
                        MODE_RI: step = read_step(ri_addr);
                        default: step = fetch_step();
                    endcase
                end else if (cur_class.mode == MODE_RI) begin
                    step       = read_step(last_ram);
                    scratch_ld = 1'b1;   // keep pointer, last_ram is overwritten
                end else begin
                    step = read_step(last_rom);
                end
            end
            OP_A_UNARY: step = unary_step(SRC_A, cur_class.alu_op);
            default:    step = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (step_accept) begin
            if (step.kind == STEP_FETCH)
                last_rom <= resp.rom_data;
            if (step.kind == STEP_RAM_READ || step.kind == STEP_PROCESS)
                last_ram <= resp.ram_data;  // alu result comes back here too
            if (scratch_ld)
                scratch <= scratch_d;
        end
    end

    // classifier must never hand over a write for a family with no write data
    a_write_src: assert property (@(posedge clk) disable iff (!rst_n)
        step_accept && step.kind == STEP_RAM_WRITE |-> step.a_src != SRC_NONE);

endmodule

/* hw/ins_decoder.sv */
// opcode in, micro-steps out over two valid/ready pairs; executor returns fetched and ram bytes in resp
`timescale 1ns/10ps
module ins_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  ins_decoder_pkg::byte_t       opcode,
    input  logic                         ins_valid,
    input  ins_decoder_pkg::reg_bank_t   register_bank,
    input  logic                         step_ready,
    input  ins_decoder_pkg::step_resp_t  resp,
    output logic                         ins_ready,
    output logic                         step_valid,
    output ins_decoder_pkg::micro_step_t step
);
    import ins_decoder_pkg::*;

    ins_class_t ins_class;   // decode of the offered opcode
    ins_class_t cur_class;   // instruction in flight
    phase_t     phase;
    logic       step_accept;

    opcode_classifier opcode_classifier_i (
        .opcode    (opcode),
        .ins_class (ins_class)
    );

    phase_sequencer phase_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ins_valid   (ins_valid),
        .ins_class   (ins_class),
        .step_ready  (step_ready),
        .ins_ready   (ins_ready),
        .step_valid  (step_valid),
        .step_accept (step_accept),
        .cur_class   (cur_class),
        .phase       (phase)
    );

    step_generator step_generator_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cur_class     (cur_class),
        .phase         (phase),
        .register_bank (register_bank),
        .step_accept   (step_accept),
        .resp          (resp),
        .step          (step)
    );

endmodule

/* bench/clock_gen.sv */
// free-running 8 ns clock; rst_n held low for 10 cycles and released on a falling edge
`timescale 1ns/10ps
module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 4;
    localparam int reset_cycles = 10;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // away from the active edge
    end

    always #(half_period) clk = ~clk;

endmodule

/* bench/ins_decoder_tb.sv */
// plays the executor; run from the project root so the golden file path resolves
`timescale 1ns/10ps
module ins_decoder_tb;
    import ins_decoder_pkg::*;

    localparam int golden_words      = 1024;
    localparam int cycles_per_record = 40;
    localparam int wait_limit        = 16;

    logic        clk;
    logic        rst_n;
    byte_t       opcode;
    logic        ins_valid;
    reg_bank_t   register_bank;
    logic        step_ready;
    step_resp_t  resp;
    logic        ins_ready;
    logic        step_valid;
    micro_step_t step;

    logic [7:0] golden [0:golden_words-1];
    int         num_records;
    logic       records_known;
    int         value_errors;
    int         step_errors;

    clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ins_decoder ins_decoder_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .opcode        (opcode),
        .ins_valid     (ins_valid),
        .register_bank (register_bank),
        .step_ready    (step_ready),
        .resp          (resp),
        .ins_ready     (ins_ready),
        .step_valid    (step_valid),
        .step          (step)
    );

    task automatic check_field(string name, int rec, int k, logic [7:0] got, logic [7:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("** Error at %0t: record %0d step %0d %s is %02h, expected %02h",
                     $time, rec, k, name, got, exp);
        end
    endtask

    task automatic compare_step(int rec, int k, int sbase);
        check_field("kind", rec, k, 8'(step.kind), golden[sbase+2]);
        check_field("addr", rec, k, step.addr, golden[sbase+3]);
        check_field("a_src", rec, k, 8'(step.a_src), golden[sbase+4]);
        check_field("b_src", rec, k, 8'(step.b_src), golden[sbase+5]);
        check_field("alu_op", rec, k, 8'(step.alu_op), golden[sbase+6]);
    endtask

    // offers one opcode, then takes its steps with random back-pressure
    task automatic run_record(int rec, int base);
        int          n;
        int          k;
        int          sbase;
        int          delay;
        int          wait_cnt;
        micro_step_t held;
        n        = golden[base+2];
        wait_cnt = 0;
        while (!ins_ready && wait_cnt < wait_limit) begin
            @(negedge clk);
            wait_cnt++;
        end
        opcode        = golden[base];
        register_bank = golden[base+1][1:0];
        ins_valid     = 1'b1;
        @(negedge clk);
        ins_valid = 1'b0;
        for (k = 0; k < n; k++) begin
            sbase = base + 3 + 7 * k;
            assert (step_valid && !ins_ready) else begin
                step_errors++;
                $display("missing step: record %0d offered only %0d of %0d steps", rec, k, n);
            end
            if (!step_valid)
                break;
            compare_step(rec, k, sbase);
            held       = step;
            delay      = $urandom % 4;
            step_ready = 1'b0;
            repeat (delay) begin
                resp = 16'($urandom);   // junk bytes the decoder must ignore
                @(negedge clk);
                assert (step_valid && step === held) else begin
                    value_errors++;
                    $display("** Error at %0t: record %0d step %0d changed before accept",
                             $time, rec, k);
                end
            end
            resp.rom_data = golden[sbase];
            resp.ram_data = golden[sbase+1];
            step_ready    = 1'b1;
            @(negedge clk);
        end
        assert (ins_ready && !step_valid) else begin
            step_errors++;
            $display("ins_ready did not rise in the cycle after record %0d", rec);
        end
        wait_cnt = 0;
        while (!ins_ready && wait_cnt < wait_limit) begin
            assert (!step_valid) else begin
                step_errors++;
                $display("extra step: record %0d offered more than %0d steps", rec, n);
            end
            step_ready = step_valid;   // drain it
            @(negedge clk);
            wait_cnt++;
        end
        step_ready = 1'b0;
        assert (ins_ready && !step_valid) else begin
            step_errors++;
            $display("decoder did not return to ready after record %0d", rec);
        end
    endtask

    initial begin
        int pos;
        int rec;
        void'($urandom(17530));
        opcode        = '0;
        ins_valid     = 1'b0;
        register_bank = '0;
        step_ready    = 1'b0;
        resp          = '0;
        value_errors  = 0;
        step_errors   = 0;
        num_records   = 0;
        records_known = 1'b0;
        $readmemh("bench/ins_decoder_golden.txt", golden);
        pos = 0;
        while (!$isunknown(golden[pos+2]) && golden[pos+2] != 8'hff) begin
            pos += 3 + 7 * golden[pos+2];
            num_records++;
        end
        assert (num_records > 0 && golden[pos+2] === 8'hff) else begin
            step_errors++;
            $display("golden file has no records or no end marker");
        end
        records_known = 1'b1;
        wait (rst_n === 1'b1);
        @(negedge clk);
        assert (ins_ready && !step_valid) else begin
            value_errors++;
            $display("** Error at %0t: after reset ins_ready=%b step_valid=%b",
                     $time, ins_ready, step_valid);
        end
        pos = 0;
        for (rec = 0; rec < num_records; rec++) begin
            run_record(rec, pos);
            pos += 3 + 7 * golden[pos+2];
        end
        $display("errors: %0d wrong values, %0d sequence", value_errors, step_errors);
        if (value_errors + step_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        wait (records_known);
        repeat (10 + cycles_per_record * (num_records + 1)) @(posedge clk);
        $display("watchdog expired before all %0d records finished", num_records);
        $display("errors: %0d wrong values, %0d sequence", value_errors, step_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* ins_decoder.f */
hw/ins_decoder_pkg.sv
hw/opcode_classifier.sv
hw/phase_sequencer.sv
hw/step_generator.sv
hw/ins_decoder.sv
bench/clock_gen.sv
bench/ins_decoder_tb.sv

/* Bender.yml */
package:
  name: ins_decoder

sources:
  - hw/ins_decoder_pkg.sv
  - hw/opcode_classifier.sv
  - hw/phase_sequencer.sv
  - hw/step_generator.sv
  - hw/ins_decoder.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/ins_decoder_tb.sv

/* bench/ins_decoder_golden.txt */
// opcode bank nsteps, then per step: rom ram (bytes returned) kind addr a_src b_src alu_op
// kind 0 fetch 1 read 2 write 3 process; src 0 A 1 ram 2 rom; nsteps ff ends the file
e8 1 02  00 5a 1 08 0 0 0  00 77 3 00 0 1 0
e7 2 03  00 3c 1 11 0 0 0  00 c4 1 3c 0 0 0  00 c4 3 00 0 1 0
e5 0 03  47 00 0 00 0 0 0  00 19 1 47 0 0 0  00 19 3 00 0 1 0
74 3 02  99 00 0 00 0 0 0  00 99 3 00 0 2 0
fb 1 01  00 00 2 0b 0 0 0
f6 3 02  00 62 1 18 0 0 0  00 00 2 62 0 0 0
f5 0 02  30 00 0 00 0 0 0  00 00 2 30 0 0 0
7d 2 02  a5 00 0 00 0 0 0  00 00 2 15 2 0 0
77 1 03  00 44 1 09 0 0 0  7e 00 0 00 0 0 0  00 00 2 44 2 0 0
75 0 03  51 00 0 00 0 0 0  c3 00 0 00 0 0 0  00 00 2 51 2 0 0
85 2 04  20 00 0 00 0 0 0  00 aa 1 20 0 0 0  61 00 0 00 0 0 0  00 00 2 61 1 0 0
00 0 00
a5 1 00
2a 3 02  00 08 1 1a 0 0 0  00 0d 3 00 0 1 1
36 0 03  00 7f 1 00 0 0 0  00 02 1 7f 0 0 0  00 81 3 00 0 1 2
95 1 03  6c 00 0 00 0 0 0  00 40 1 6c 0 0 0  00 2c 3 00 0 1 3
44 2 02  0f 00 0 00 0 0 0  00 ff 3 00 0 2 4
5f 2 02  00 f0 1 17 0 0 0  00 30 3 00 0 1 5
65 0 03  3e 00 0 00 0 0 0  00 55 1 3e 0 0 0  00 aa 3 00 0 1 6
04 1 01  00 01 3 00 0 0 7
1c 1 03  00 10 1 0c 0 0 0  00 0f 3 00 1 0 8  ee 00 2 0c 1 0 0
05 0 04  2d 00 0 00 0 0 0  ff 80 1 2d 0 0 0  ff 81 3 00 1 0 7  ff 00 2 2d 1 0 0
17 3 04  00 4b 1 19 0 0 0  00 20 1 4b 0 0 0  00 1f 3 00 1 0 8  00 00 2 4b 1 0 0
e4 2 01  00 00 3 00 0 0 9
f4 0 01  00 ff 3 00 0 0 a
06 2 04  00 33 1 10 0 0 0  00 05 1 33 0 0 0  00 06 3 00 1 0 7  00 00 2 33 1 0 0
00 0 ff
